// File: build.f
+incdir+.
nand_cpu_pkg.sv
icache_control.sv
icache_tag_store.sv
icache_data_store.sv
instr_memory.sv
icache_top.sv
tb_icache.sv

// File: icache_control.sv
`timescale 1ns/100ps

`include "nand_cpu_settings.svh"

module icache_control (
    input  logic clk,
    input  logic n_rst,
    input  logic lookup_hit,
    input  logic mem_ack,
    output logic mem_req,
    output logic fill_beat_en,
    output logic [nand_cpu_pkg::beat_bits-1:0] beat_index,
    output logic fill_done,
    output logic hit
);
    import nand_cpu_pkg::*;

    cache_state state;
    cache_state next_state;

    logic [beat_bits-1:0] beat_cnt;
    logic last_beat;

    assign last_beat = &beat_cnt;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= READY;
            beat_cnt <= '0;
        end else begin
            state <= next_state;
            // Wraps back to zero after the last beat.
            if (fill_beat_en) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            READY: begin
                if (!lookup_hit) begin
                    next_state = REQUEST_READ;
                end
            end
            REQUEST_READ: begin
                if (mem_ack) begin
                    next_state = READING;
                end
            end
            READING: begin
                if (last_beat) begin
                    next_state = READY;
                end
            end
            default: begin
                next_state = READY;
            end
        endcase
    end

    // Request stays up until the memory acks.
    assign mem_req = (state == REQUEST_READ);

    // One beat lands per cycle while reading.
    assign fill_beat_en = (state == READING);
    assign beat_index = beat_cnt;
    assign fill_done = (state == READING) && last_beat; // Line becomes valid.

    // Hits only count once the FSM is idle.
    assign hit = (state == READY) && lookup_hit;

endmodule

// File: icache_data_store.sv
`timescale 1ns/100ps

`include "nand_cpu_settings.svh"

module icache_data_store (
    input  logic clk,
    input  logic [`CACHE_INDEX_BITS-1:0] index,
    input  logic [nand_cpu_pkg::offset_bits-1:0] offset,
    input  logic fill_beat_en,
    input  logic [nand_cpu_pkg::beat_bits-1:0] beat_index,
    input  logic [`MEM_TRANS_SIZE-1:0] mem_data,
    output logic [7:0] data
);

    localparam int line_count = 1 << `CACHE_INDEX_BITS;

    logic [`CACHE_BLOCK_SIZE-1:0] blocks [line_count];

    // Beat 0 is the low slice of the block.
    always_ff @(posedge clk) begin
        if (fill_beat_en) begin
            blocks[index][beat_index * `MEM_TRANS_SIZE +: `MEM_TRANS_SIZE] <= mem_data;
        end
    end

    // Byte select by offset, lowest byte first.
    assign data = blocks[index][offset * 8 +: 8];

endmodule

// File: icache_tag_store.sv
`timescale 1ns/100ps

`include "nand_cpu_settings.svh"

module icache_tag_store (
    input  logic clk,
    input  logic n_rst,
    input  logic [`CACHE_INDEX_BITS-1:0] index,
    input  logic [nand_cpu_pkg::tag_bits-1:0] tag,
    input  logic fill_done,
    output logic lookup_hit
);
    import nand_cpu_pkg::*;

    localparam int line_count = 1 << `CACHE_INDEX_BITS;

    logic [line_count-1:0] valid;
    logic [tag_bits-1:0] tags [line_count];

    // Every line starts out invalid.
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            valid <= '0;
        end else if (fill_done) begin
            valid[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tags[index] <= tag;
        end
    end

    // Combinational lookup.
    assign lookup_hit = valid[index] && (tags[index] == tag);

endmodule

// File: icache_top.sv
`timescale 1ns/100ps

`include "nand_cpu_settings.svh"

module icache_top (
    input  logic clk,
    input  logic n_rst,
    input  logic [`PC_SIZE-1:0] pc,
    input  logic load_en,
    input  logic [`MEM_ADDR_BITS-1:0] load_addr,
    input  logic [7:0] load_data,
    output logic hit,
    output logic [7:0] data
);
    import nand_cpu_pkg::*;

    logic [offset_bits-1:0] offset;
    logic [`CACHE_INDEX_BITS-1:0] index;
    logic [tag_bits-1:0] tag;
    logic [block_addr_bits-1:0] mem_addr;

    logic mem_req;
    logic mem_ack;
    logic [`MEM_TRANS_SIZE-1:0] mem_data;

    logic fill_beat_en;
    logic [beat_bits-1:0] beat_index;
    logic fill_done;
    logic lookup_hit;

    // Tag | index | offset.
    assign offset = pc[offset_bits-1:0];
    assign index = pc[offset_bits +: `CACHE_INDEX_BITS];
    assign tag = pc[`PC_SIZE-1 -: tag_bits];
    assign mem_addr = pc[`PC_SIZE-1:offset_bits]; // Block address.

    icache_control i_icache_control (
        .clk          (clk),
        .n_rst        (n_rst),
        .lookup_hit   (lookup_hit),
        .mem_ack      (mem_ack),
        .mem_req      (mem_req),
        .fill_beat_en (fill_beat_en),
        .beat_index   (beat_index),
        .fill_done    (fill_done),
        .hit          (hit)
    );

    icache_tag_store i_icache_tag_store (
        .clk        (clk),
        .n_rst      (n_rst),
        .index      (index),
        .tag        (tag),
        .fill_done  (fill_done),
        .lookup_hit (lookup_hit)
    );

    icache_data_store i_icache_data_store (
        .clk          (clk),
        .index        (index),
        .offset       (offset),
        .fill_beat_en (fill_beat_en),
        .beat_index   (beat_index),
        .mem_data     (mem_data),
        .data         (data)
    );

    instr_memory i_instr_memory (
        .clk       (clk),
        .n_rst     (n_rst),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ack   (mem_ack),
        .mem_data  (mem_data),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

// File: instr_memory.sv
`timescale 1ns/100ps

`include "nand_cpu_settings.svh"

module instr_memory (
    input  logic clk,
    input  logic n_rst,
    input  logic mem_req,
    input  logic [`PC_SIZE-$clog2(`CACHE_BLOCK_SIZE/8)-1:0] mem_addr,
    output logic mem_ack,
    output logic [`MEM_TRANS_SIZE-1:0] mem_data,
    input  logic load_en,
    input  logic [`MEM_ADDR_BITS-1:0] load_addr,
    input  logic [7:0] load_data
);

    localparam int off_bits = $clog2(`CACHE_BLOCK_SIZE / 8);
    localparam int beat_w = $clog2(`CACHE_BLOCK_SIZE / `MEM_TRANS_SIZE);
    localparam int bytes_per_beat = `MEM_TRANS_SIZE / 8;
    localparam int sel_bits = $clog2(bytes_per_beat);
    localparam int lat_w = $clog2(`MEM_LATENCY) + 1;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_WAIT,
        MEM_ACK,
        MEM_STREAM
    } mem_phase;

    logic [7:0] mem [1 << `MEM_ADDR_BITS];

    mem_phase phase;
    logic [lat_w-1:0] lat_cnt;
    logic [beat_w-1:0] beat;
    logic [`MEM_ADDR_BITS-off_bits-1:0] blk_addr;
    logic [`MEM_ADDR_BITS-1:0] beat_base;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            phase <= MEM_IDLE;
            lat_cnt <= '0;
            beat <= '0;
        end else begin
            case (phase)
                MEM_IDLE: begin
                    // Requests are only taken here.
                    if (mem_req) begin
                        phase <= (`MEM_LATENCY > 1) ? MEM_WAIT : MEM_ACK;
                        lat_cnt <= lat_w'(`MEM_LATENCY - 1);
                    end
                end
                MEM_WAIT: begin
                    lat_cnt <= lat_cnt - 1'b1;
                    if (lat_cnt <= 1) begin
                        phase <= MEM_ACK;
                    end
                end
                MEM_ACK: begin
                    phase <= MEM_STREAM;
                    beat <= '0;
                end
                MEM_STREAM: begin
                    beat <= beat + 1'b1;
                    if (&beat) begin
                        phase <= MEM_IDLE;
                    end
                end
                default: begin
                    phase <= MEM_IDLE;
                end
            endcase
        end
    end

    // Block address is latched when a request is taken.
    always_ff @(posedge clk) begin
        if (phase == MEM_IDLE && mem_req) begin
            blk_addr <= mem_addr[`MEM_ADDR_BITS-off_bits-1:0];
        end
    end

    assign mem_ack = (phase == MEM_ACK);

    assign beat_base = {blk_addr, beat, {sel_bits{1'b0}}};

    // Lower address goes in the low byte.
    always_comb begin
        for (int i = 0; i < bytes_per_beat; i++) begin
            mem_data[i * 8 +: 8] = mem[beat_base + `MEM_ADDR_BITS'(i)];
        end
    end

endmodule

// File: nand_cpu_pkg.sv
`include "nand_cpu_settings.svh"

package nand_cpu_pkg;

    typedef enum logic [1:0] {
        READY,
        REQUEST_READ,
        READING
    } cache_state;

    // Field widths derived from the settings.
    localparam int offset_bits = $clog2(`CACHE_BLOCK_SIZE / 8);
    localparam int beat_bits = $clog2(`CACHE_BLOCK_SIZE / `MEM_TRANS_SIZE);
    localparam int tag_bits = `PC_SIZE - `CACHE_INDEX_BITS - offset_bits;
    localparam int block_addr_bits = `PC_SIZE - offset_bits;

endpackage

// File: nand_cpu_settings.svh
`ifndef NAND_CPU_SETTINGS_SVH
`define NAND_CPU_SETTINGS_SVH

// Fetch address width.
`define PC_SIZE 16

// Cache block in bits (eight instruction bytes).
`define CACHE_BLOCK_SIZE 64

// One memory beat in bits.
`define MEM_TRANS_SIZE 16

// 16 lines.
`define CACHE_INDEX_BITS 4

// Instruction memory byte address width.
`define MEM_ADDR_BITS 10

// Cycles from request accept to ack.
`define MEM_LATENCY 3

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_icache -o tb_icache_sim

output=$(./obj_dir/tb_icache_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "All tests passed"; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tb_icache.sv
`timescale 1ns/100ps

`include "nand_cpu_settings.svh"

module tb_icache;

    localparam int clk_period = 100;
    localparam int sample_delay = clk_period / 4;
    localparam int reset_cycles = 8;
    localparam int mem_bytes = 1 << `MEM_ADDR_BITS;
    localparam int block_bytes = `CACHE_BLOCK_SIZE / 8;
    localparam int off_w = $clog2(block_bytes);
    localparam int lines = 1 << `CACHE_INDEX_BITS;
    localparam int tag_w = `PC_SIZE - `CACHE_INDEX_BITS - off_w;
    localparam int beats = `CACHE_BLOCK_SIZE / `MEM_TRANS_SIZE;

    localparam int fill_blocks = 4;
    localparam int seq_blocks = 6;
    localparam int evict_rounds = 3;
    localparam int random_fetches = 400;
    localparam int total_fetches = 1 + (fill_blocks + seq_blocks) * block_bytes
        + 2 + 2 * evict_rounds + random_fetches;

    // Upper bound on one fetch including a miss.
    localparam int miss_bound = `MEM_LATENCY + 2 * beats + 8;
    localparam int watchdog_cycles = total_fetches * miss_bound + mem_bytes + reset_cycles + 16;

    logic clk;
    logic n_rst;
    logic [`PC_SIZE-1:0] pc;
    logic load_en;
    logic [`MEM_ADDR_BITS-1:0] load_addr;
    logic [7:0] load_data;
    logic hit;
    logic [7:0] data;

    logic [7:0] program_copy [mem_bytes];
    logic [lines-1:0] model_valid;
    logic [tag_w-1:0] model_tag [lines];
    logic checking;

    icache_top i_icache_top (
        .clk       (clk),
        .n_rst     (n_rst),
        .pc        (pc),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .hit       (hit),
        .data      (data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [7:0] expected_byte(input logic [`PC_SIZE-1:0] addr);
        logic [`MEM_ADDR_BITS-1:0] wrapped;
        wrapped = addr[`MEM_ADDR_BITS-1:0]; // Memory repeats every 1 KB.
        return program_copy[wrapped];
    endfunction

    function automatic logic expected_hit(input logic [`PC_SIZE-1:0] addr);
        logic [`CACHE_INDEX_BITS-1:0] idx;
        logic [tag_w-1:0] tg;
        idx = addr[off_w +: `CACHE_INDEX_BITS];
        tg = addr[`PC_SIZE-1 -: tag_w];
        return model_valid[idx] && (model_tag[idx] == tg);
    endfunction

    task automatic update_model(input logic [`PC_SIZE-1:0] addr);
        logic [`CACHE_INDEX_BITS-1:0] idx;
        idx = addr[off_w +: `CACHE_INDEX_BITS];
        model_valid[idx] = 1'b1;
        model_tag[idx] = addr[`PC_SIZE-1 -: tag_w];
    endtask

    task automatic load_program();
        for (int i = 0; i < mem_bytes; i++) begin
            @(negedge clk);
            load_en = 1'b1;
            load_addr = `MEM_ADDR_BITS'(i);
            load_data = 8'($urandom);
            program_copy[load_addr] = load_data;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk);
        n_rst = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        n_rst = 1'b1;
        model_valid = '0; // All lines start invalid.
    endtask

    // Plays the CPU and holds pc until hit rises.
    task automatic fetch(input logic [`PC_SIZE-1:0] addr, output logic first_hit);
        logic predicted;
        predicted = expected_hit(addr);
        @(negedge clk);
        pc = addr;
        #(sample_delay);
        first_hit = hit;
        assert (hit == predicted) else begin
            $display("Fail at %0t ns: pc %h gave hit %b, model expects %b",
                $time, addr, hit, predicted);
            $display("Some tests failed");
            $fatal(1, "hit prediction mismatch");
        end
        while (!hit) begin
            @(negedge clk);
            #(sample_delay);
        end
        if (!predicted) begin
            update_model(addr);
        end
    endtask

    // Compares every delivered instruction byte.
    always begin
        @(negedge clk);
        #(sample_delay);
        if (checking && hit) begin
            assert (data == expected_byte(pc)) else begin
                $display("Fail at %0t ns: pc %h gave data %h, expected %h",
                    $time, pc, data, expected_byte(pc));
                $display("Some tests failed");
                $fatal(1, "data mismatch");
            end
        end
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Error: fetching hung, no result after %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        logic h;
        logic [`PC_SIZE-1:0] base;
        logic [`PC_SIZE-1:0] addr;
        logic [`PC_SIZE-1:0] evict_a;
        logic [`PC_SIZE-1:0] evict_b;
        int first_off;
        int misses;

        n_rst = 1'b1;
        pc = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        checking = 1'b0;
        model_valid = '0;
        void'($urandom(29));

        // Program goes in before reset so the cache starts clean.
        load_program();
        apply_reset();
        checking = 1'b1;

        // Block 0 is the first fetch since pc sits at 0 through reset.
        fetch('0, h);
        assert (!h) else begin
            $display("Fail at %0t ns: first fetch after reset hit", $time);
            $display("Some tests failed");
            $fatal(1, "cold miss expected");
        end

        // Rest of a freshly filled block hits at once.
        for (int b = 0; b < fill_blocks; b++) begin
            base = `PC_SIZE'($urandom_range(16'h0100, 16'h3fff));
            base[off_w-1:0] = '0;
            first_off = $urandom_range(0, block_bytes - 1);
            fetch(base | `PC_SIZE'(first_off), h);
            for (int o = 0; o < block_bytes; o++) begin
                if (o != first_off) begin
                    fetch(base | `PC_SIZE'(o), h);
                    assert (h) else begin
                        $display("Fail at %0t ns: offset %0d of filled block %h missed",
                            $time, o, base);
                        $display("Some tests failed");
                        $fatal(1, "hit after fill expected");
                    end
                end
            end
        end

        // Straight-line code across block boundaries.
        base = 16'h8040;
        misses = 0;
        for (int i = 0; i < seq_blocks * block_bytes; i++) begin
            fetch(base + `PC_SIZE'(i), h);
            if (!h) misses++;
        end
        assert (misses == seq_blocks) else begin
            $display("Fail at %0t ns: sequential fetch saw %0d misses, expected %0d",
                $time, misses, seq_blocks);
            $display("Some tests failed");
            $fatal(1, "sequential miss count");
        end

        // Two tags that share one index.
        evict_a = 16'hc0a5;
        evict_b = 16'he0a5;
        fetch(evict_a, h);
        fetch(evict_b, h);
        misses = 0;
        for (int r = 0; r < evict_rounds; r++) begin
            fetch(evict_a, h);
            if (!h) misses++;
            fetch(evict_b, h);
            if (!h) misses++;
        end
        assert (misses == 2 * evict_rounds) else begin
            $display("Fail at %0t ns: conflicting lines missed %0d times, expected %0d",
                $time, misses, 2 * evict_rounds);
            $display("Some tests failed");
            $fatal(1, "eviction miss count");
        end

        // Mostly a small hot window with the odd far address.
        for (int i = 0; i < random_fetches; i++) begin
            if ($urandom_range(0, 3) == 0) begin
                addr = `PC_SIZE'($urandom);
            end else begin
                addr = 16'h2000 + `PC_SIZE'($urandom_range(0, 255));
            end
            fetch(addr, h);
        end

        $display("All tests passed");
        $finish;
    end

endmodule
